// ==== hw/nccPkg.sv ====
package nccPkg;

	// pixel geometry
	localparam int PixelWidth = 9;
	// descriptor pixels per input beat
	localparam int BeatPixels = 4;

	// leading-one position, 0 to 8
	localparam int ExpWidth = 4;
	// Mitchell fraction, exact for 9-bit pixels
	localparam int LogFracWidth = 8;

	// signed product, magnitude up to 2^16
	localparam int ProdWidth = 18;
	// tree accumulator width
	localparam int SumWidth = 32;

	// one signed image or descriptor pixel
	typedef logic signed [PixelWidth-1:0] pixel_t;

	// element 3 is the first pixel in fill order
	typedef pixel_t [BeatPixels-1:0] descBeat_t;

	// log-domain pixel
	typedef struct packed {
		// pixel was zero, product forced to zero
		logic zero;
		// sign of the original pixel
		logic sign;
		// leading-one position of the magnitude
		logic [ExpWidth-1:0] exponent;
		// bits below the leading one, left aligned
		logic [LogFracWidth-1:0] fraction;
	} logPixel_t;

	// one PE output
	typedef logic signed [ProdWidth-1:0] product_t;

	// running and final tree sums
	typedef logic signed [SumWidth-1:0] sum_t;

endpackage

// ==== hw/log2Convert.sv ====
`timescale 1ns/100ps

module log2Convert (
	input nccPkg::pixel_t pixel,
	output nccPkg::logPixel_t logVal
);
	import nccPkg::*;

	// absolute value, -256 comes out as 256
	logic [PixelWidth-1:0] mag;
	// low byte and its normalized versions
	logic [LogFracWidth-1:0] low;
	logic [LogFracWidth-1:0] step4;
	logic [LogFracWidth-1:0] step2;
	logic [LogFracWidth-1:0] step1;
	// exponent bits found per search step
	logic hit4;
	logic hit2;
	logic hit1;

	assign mag = pixel[PixelWidth-1] ? -pixel : pixel;
	assign low = mag[LogFracWidth-1:0];

	always_comb begin
		// upper nibble first
		hit4 = |low[7:4];
		step4 = hit4 ? low : low << 4;
		// then upper pair
		hit2 = |step4[7:6];
		step2 = hit2 ? step4 : step4 << 2;
		// then top bit, leaves leading one at bit 7
		hit1 = step2[7];
		step1 = hit1 ? step2 : step2 << 1;

		logVal.zero = (mag == '0);
		logVal.sign = pixel[PixelWidth-1];
		// bit 8 set only for magnitude 256
		if (mag[PixelWidth-1]) begin
			logVal.exponent = ExpWidth'(LogFracWidth);
			logVal.fraction = low;
		end else begin
			logVal.exponent = {1'b0, hit4, hit2, hit1};
			// drop the leading one, keep what follows it
			logVal.fraction = {step1[LogFracWidth-2:0], 1'b0};
		end
	end

endmodule

// ==== hw/descLoader.sv ====
`timescale 1ns/100ps

module descLoader #(
	parameter int gridDim = 16
) (
	input logic clk,
	input logic rst,
	input logic descValid,
	input nccPkg::descBeat_t descData,
	output nccPkg::logPixel_t [gridDim*gridDim-1:0] descLog
);
	import nccPkg::*;

	// beats needed to fill one row
	localparam int GroupCount = gridDim / BeatPixels;
	// keep the group counter at least one bit for small grids
	localparam int GroupBits = (GroupCount > 1) ? $clog2(GroupCount) : 1;
	localparam int RowBits = $clog2(gridDim);
	localparam int CellBits = $clog2(gridDim * gridDim);

	logic [RowBits-1:0] row;
	logic [GroupBits-1:0] colGroup;
	// flat index of the first cell this beat writes
	logic [CellBits-1:0] cellBase;
	logPixel_t [BeatPixels-1:0] beatLog;

	// one converter per beat lane
	for (genvar b = 0; b < BeatPixels; b++) begin : gConv
		log2Convert uConv (
			.pixel(descData[b]),
			.logVal(beatLog[b])
		);
	end

	assign cellBase = CellBits'(row * gridDim + colGroup * BeatPixels);

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			descLog <= '0;
			row <= '0;
			colGroup <= '0;
		end else if (descValid) begin
			// lane 3 lands in the leftmost column of the group
			for (int i = 0; i < BeatPixels; i++) begin
				descLog[cellBase + CellBits'(i)] <= beatLog[BeatPixels-1-i];
			end
			// row done, move down, wrap after the last row
			if (colGroup == GroupBits'(GroupCount - 1)) begin
				colGroup <= '0;
				row <= (row == RowBits'(gridDim - 1)) ? '0 : row + 1'b1;
			end else begin
				colGroup <= colGroup + 1'b1;
			end
		end
	end

endmodule

// ==== hw/windowLoader.sv ====
`timescale 1ns/100ps

module windowLoader #(
	parameter int gridDim = 16
) (
	input logic clk,
	input logic rst,
	input logic winValid,
	input nccPkg::pixel_t [gridDim*gridDim-1:0] winData,
	output nccPkg::logPixel_t [gridDim*gridDim-1:0] winLog,
	output logic prodValid
);
	import nccPkg::*;

	localparam int CellCount = gridDim * gridDim;

	// converted window, not yet latched
	logPixel_t [CellCount-1:0] convLog;

	// full-width conversion, one per pixel
	for (genvar p = 0; p < CellCount; p++) begin : gConv
		log2Convert uConv (
			.pixel(winData[p]),
			.logVal(convLog[p])
		);
	end

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			winLog <= '0;
			prodValid <= 1'b0;
		end else begin
			// products are ready the cycle after the strobe
			prodValid <= winValid;
			if (winValid) begin
				winLog <= convLog;
			end
		end
	end

endmodule

// ==== hw/logProduct.sv ====
`timescale 1ns/100ps

module logProduct (
	input nccPkg::logPixel_t descLog,
	input nccPkg::logPixel_t winLog,
	output nccPkg::product_t product
);
	import nccPkg::*;

	// implicit leading one plus fraction
	localparam int MantWidth = LogFracWidth + 1;
	// room for the largest shift, 8 + 8
	localparam int ScaleWidth = MantWidth + 2 * LogFracWidth;

	logic [ExpWidth:0] expSum;
	logic [ExpWidth:0] shiftExp;
	// fraction sum in units of 2^-8, top bit is the carry
	logic [LogFracWidth:0] fracSum;
	logic [MantWidth-1:0] mant;
	logic [ScaleWidth-1:0] scaled;
	logic [ProdWidth-2:0] magnitude;

	always_comb begin
		// log add
		expSum = descLog.exponent + winLog.exponent;
		fracSum = descLog.fraction + winLog.fraction;

		// on carry, 1+f becomes 2*(1+(f-1)), so bump the exponent
		mant = {1'b1, fracSum[LogFracWidth-1:0]};
		shiftExp = expSum + fracSum[LogFracWidth];

		// antilog, then drop the fraction bits
		scaled = ScaleWidth'(mant) << shiftExp;
		magnitude = scaled[ScaleWidth-1:LogFracWidth];

		// zero operand wins over everything
		if (descLog.zero || winLog.zero) begin
			product = '0;
		end else if (descLog.sign ^ winLog.sign) begin
			product = -$signed({1'b0, magnitude});
		end else begin
			product = $signed({1'b0, magnitude});
		end
	end

endmodule

// ==== hw/adderTree.sv ====
`timescale 1ns/100ps

module adderTree #(
	parameter int gridDim = 16
) (
	input logic clk,
	input logic rst,
	input logic prodValid,
	input nccPkg::product_t [gridDim*gridDim-1:0] products,
	output nccPkg::sum_t sum,
	output logic sumValid
);
	import nccPkg::*;

	localparam int LeafCount = gridDim * gridDim;
	// one register level per halving
	localparam int Levels = $clog2(LeafCount);

	// sign-extended products
	sum_t [LeafCount-1:0] leaf;
	// registered partial sums, heap order, node 1 is the root
	sum_t [LeafCount-1:1] node;
	// leaves above internal nodes, children of k at 2k and 2k+1
	sum_t [2*LeafCount-1:1] heap;
	// valid bit as it moves toward the root
	logic [Levels-1:0] validPipe;
	// load enable per level, bit 0 nearest the leaves
	logic [Levels-1:0] levelEn;

	always_comb begin
		for (int i = 0; i < LeafCount; i++) begin
			leaf[i] = {{(SumWidth - ProdWidth){products[i][ProdWidth-1]}}, products[i]};
		end
	end

	assign heap = {leaf, node};
	assign levelEn = {validPipe[Levels-2:0], prodValid};

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			node <= '0;
			validPipe <= '0;
		end else begin
			validPipe <= levelEn;
			// depth d holds nodes 2^d to 2^(d+1)-1
			for (int d = 0; d < Levels; d++) begin
				// only the level whose inputs just settled
				if (levelEn[Levels-1-d]) begin
					for (int k = 1 << d; k < 2 << d; k++) begin
						node[k] <= heap[2*k] + heap[2*k+1];
					end
				end
			end
		end
	end

	assign sum = node[1];
	assign sumValid = validPipe[Levels-1];

endmodule

// ==== hw/nccNumerator.sv ====
`timescale 1ns/100ps

module nccNumerator #(
	parameter int gridDim = 16
) (
	input logic clk,
	input logic rst,
	input logic descValid,
	input nccPkg::descBeat_t descData,
	input logic winValid,
	input nccPkg::pixel_t [gridDim*gridDim-1:0] winData,
	output nccPkg::sum_t sum,
	output logic sumValid
);
	import nccPkg::*;

	localparam int CellCount = gridDim * gridDim;

	logPixel_t [CellCount-1:0] descLog;
	logPixel_t [CellCount-1:0] winLog;
	product_t [CellCount-1:0] products;
	// first cycle of a product wave
	logic prodValid;

	descLoader #(.gridDim(gridDim)) uDesc (
		.clk(clk),
		.rst(rst),
		.descValid(descValid),
		.descData(descData),
		.descLog(descLog)
	);

	windowLoader #(.gridDim(gridDim)) uWin (
		.clk(clk),
		.rst(rst),
		.winValid(winValid),
		.winData(winData),
		.winLog(winLog),
		.prodValid(prodValid)
	);

	// PE grid, row major in the flat arrays
	for (genvar r = 0; r < gridDim; r++) begin : gRow
		for (genvar c = 0; c < gridDim; c++) begin : gCol
			logProduct uPe (
				.descLog(descLog[r*gridDim+c]),
				.winLog(winLog[r*gridDim+c]),
				.product(products[r*gridDim+c])
			);
		end
	end

	adderTree #(.gridDim(gridDim)) uTree (
		.clk(clk),
		.rst(rst),
		.prodValid(prodValid),
		.products(products),
		.sum(sum),
		.sumValid(sumValid)
	);

endmodule

// ==== sim/nccNumerator_chk.sv ====
`timescale 1ns/100ps

module nccNumeratorChk (
	input logic clk,
	input logic rst,
	input logic winValid,
	input logic prodValid,
	input nccPkg::sum_t sum,
	input logic sumValid
);
	import nccPkg::*;

	// window latch, then eight tree levels for a 16x16 grid
	localparam int Latency = 9;

	// read by the testbench
	int failCount = 0;

	// cleared while in reset and on the first edge after it
	resetState: assert property (@(posedge clk) $past(rst) |-> !sumValid && !prodValid && sum == '0)
		else begin
			$error("pipeline not cleared by reset");
			failCount++;
		end

	// each sampled window gives a result Latency edges later
	resultFollows: assert property (@(posedge clk) disable iff (rst)
		$past(winValid, Latency) |-> sumValid)
		else begin
			$error("sumValid missing after a window strobe");
			failCount++;
		end

	// and no result without a window
	noStrayResult: assert property (@(posedge clk) disable iff (rst)
		sumValid |-> $past(winValid, Latency))
		else begin
			$error("sumValid high with no window strobe before it");
			failCount++;
		end

endmodule

bind nccNumerator nccNumeratorChk uChk (
	.clk(clk),
	.rst(rst),
	.winValid(winValid),
	.prodValid(prodValid),
	.sum(sum),
	.sumValid(sumValid)
);

// ==== sim/nccNumeratorTb.sv ====
`timescale 1ns/100ps

module nccNumeratorTb;
	import nccPkg::*;

	localparam int GridDim = 16;
	localparam int CellCount = GridDim * GridDim;
	localparam int GroupCount = GridDim / BeatPixels;
	localparam int BeatsPerDesc = CellCount / BeatPixels;
	// whole run: 4 + 4 + 8 + 1 windows, three descriptor loads
	localparam int WindowCount = 17;
	localparam int DescLoads = 3;
	localparam int ClkPeriod = 4;
	// longest wait for the last result of a burst
	localparam int DrainCycles = 20;

	logic clk;
	logic rst;
	logic descValid;
	descBeat_t descData;
	logic winValid;
	pixel_t [CellCount-1:0] winData;
	sum_t sum;
	logic sumValid;

	integer seed;
	// descriptor as the DUT should hold it, row major
	int descModel [CellCount];
	// beat position inside one descriptor, wraps like the DUT counters
	int beatIdx;
	// expected sums, oldest window first
	sum_t expQ [$];

	nccNumerator #(.gridDim(GridDim)) uut (
		.clk(clk),
		.rst(rst),
		.descValid(descValid),
		.descData(descData),
		.winValid(winValid),
		.winData(winData),
		.sum(sum),
		.sumValid(sumValid)
	);

	always #(ClkPeriod / 2) clk = ~clk;

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	// position of the leading one, m is 1 to 256
	function automatic int leadOne(input int m);
		int e;
		e = 0;
		for (int b = 0; b <= 8; b++) begin
			if (m >= (1 << b)) begin
				e = b;
			end
		end
		return e;
	endfunction

	// Mitchell product of two signed pixels
	function automatic longint mitchellProduct(input int a, input int b);
		int ma;
		int mb;
		int e;
		int f;
		longint mag;
		ma = (a < 0) ? -a : a;
		mb = (b < 0) ? -b : b;
		if (ma == 0 || mb == 0) begin
			mag = 0;
		end else begin
			e = leadOne(ma) + leadOne(mb);
			// fractions in units of 2^-8
			f = ((ma - (1 << leadOne(ma))) << (8 - leadOne(ma)))
				+ ((mb - (1 << leadOne(mb))) << (8 - leadOne(mb)));
			if (f < 256) begin
				mag = (longint'(256 + f) << e) >> 8;
			end else begin
				// fraction carry doubles the scale
				mag = (longint'(f) << (e + 1)) >> 8;
			end
		end
		return ((a < 0) != (b < 0)) ? -mag : mag;
	endfunction

	function automatic sum_t modelSum(input pixel_t [CellCount-1:0] win);
		longint acc;
		acc = 0;
		for (int p = 0; p < CellCount; p++) begin
			acc += mitchellProduct(descModel[p], int'(win[p]));
		end
		return sum_t'(acc);
	endfunction

	// plain dot product, valid when every descriptor pixel is 0 or a power of two
	function automatic sum_t exactSum(input pixel_t [CellCount-1:0] win);
		longint acc;
		acc = 0;
		for (int p = 0; p < CellCount; p++) begin
			acc += longint'(descModel[p]) * longint'(int'(win[p]));
		end
		return sum_t'(acc);
	endfunction

	// 64 back to back beats; powers picks 0 or signed powers of two
	task automatic loadDescriptor(input bit powers);
		pixel_t px;
		int base;
		int k;
		for (int n = 0; n < BeatsPerDesc; n++) begin
			@(posedge clk);
			#1;
			base = (beatIdx / GroupCount) * GridDim + (beatIdx % GroupCount) * BeatPixels;
			for (int i = 0; i < BeatPixels; i++) begin
				if (powers) begin
					k = $unsigned($random(seed)) % 10;
					// 1 << 8 wraps to -256
					px = (k == 9) ? pixel_t'(0) : pixel_t'(1 << k);
					if (k < 8 && ($random(seed) & 1)) begin
						px = -px;
					end
				end else begin
					px = pixel_t'($random(seed));
				end
				// first pixel of a beat rides in element 3
				descData[BeatPixels-1-i] = px;
				descModel[base + i] = int'(px);
			end
			descValid = 1'b1;
			beatIdx = (beatIdx + 1) % BeatsPerDesc;
		end
		@(posedge clk);
		#1;
		descValid = 1'b0;
	endtask

	// count windows on consecutive cycles, expected sums queued in order
	task automatic sendWindows(input int count, input bit exact);
		for (int w = 0; w < count; w++) begin
			@(posedge clk);
			#1;
			for (int p = 0; p < CellCount; p++) begin
				winData[p] = pixel_t'($random(seed));
			end
			winValid = 1'b1;
			expQ.push_back(exact ? exactSum(winData) : modelSum(winData));
		end
		@(posedge clk);
		#1;
		winValid = 1'b0;
	endtask

	// wait for the queue to empty, but not past the tree depth plus margin
	task automatic drainResults();
		int waited;
		waited = 0;
		while (expQ.size() != 0 && waited < DrainCycles) begin
			@(posedge clk);
			waited++;
		end
	endtask

	// outputs settle after the rising edge, read them mid cycle
	always @(negedge clk) begin : resultCheck
		sum_t expected;
		if (uut.uChk.failCount != 0) begin
			abortRun("a bound timing or reset assertion failed");
		end else if (!rst && sumValid) begin
			if (expQ.size() == 0) begin
				abortRun("sumValid went high with no window pending");
			end else begin
				expected = expQ.pop_front();
				assert (sum == expected) else begin
					abortRun($sformatf("FAIL sum expected 0x%h actual 0x%h", expected, sum));
				end
			end
		end
	end

	// generous budget per window plus the descriptor loads
	initial begin
		#((WindowCount * 20 + DescLoads * (BeatsPerDesc + 1) + 8) * ClkPeriod);
		abortRun("timeout, the results did not all arrive");
	end

	initial begin
		seed = 32'h7a980548;
		clk = 1'b0;
		rst = 1'b1;
		descValid = 1'b0;
		descData = '0;
		winValid = 1'b0;
		winData = '0;
		beatIdx = 0;
		for (int p = 0; p < CellCount; p++) begin
			descModel[p] = 0;
		end
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;

		// powers of two make the log product exact
		loadDescriptor(1'b1);
		for (int w = 0; w < 4; w++) begin
			sendWindows(1, 1'b1);
			drainResults();
		end

		// full range descriptor, counters wrap into row 0 again
		loadDescriptor(1'b0);
		for (int w = 0; w < 4; w++) begin
			sendWindows(1, 1'b0);
			drainResults();
		end

		// eight windows in flight at once
		sendWindows(8, 1'b0);
		drainResults();

		// another 64 beats overwrite the whole descriptor
		loadDescriptor(1'b0);
		sendWindows(1, 1'b0);
		drainResults();

		if (expQ.size() != 0) begin
			abortRun("results still pending at the end of the run");
		end else begin
			$display("*** TEST PASSED ***");
			$finish;
		end
	end

endmodule

// ==== project.f ====
hw/nccPkg.sv
hw/log2Convert.sv
hw/descLoader.sv
hw/windowLoader.sv
hw/logProduct.sv
hw/adderTree.sv
hw/nccNumerator.sv
sim/nccNumerator_chk.sv
sim/nccNumeratorTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := nccNumeratorTb
FILELIST  := project.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0 --top-module $(TOP) --Mdir $(BUILD_DIR)
SIM_ARGS  := +verilator+error+limit+100
LOG       := sim.log
PASS_MSG  := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
